// ==== hw/rv_core_pkg.sv ====
// RV64I core definitions
`default_nettype none

package rv_core_pkg;

  localparam int XLEN     = 64;
  localparam int NUM_REGS = 32;

  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

  // Major opcodes.
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_PRIV = 3'b000;  // EBREAK and ECALL space.
  localparam logic [6:0] F7_ADD  = 7'b0000000;

  // One instruction word seen through the base formats.
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic        imm20;   // Sign bit.
      logic [9:0]  imm10_1;
      logic        imm11;
      logic [7:0]  imm19_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } j;
  } rv_inst_u;

  typedef enum logic [2:0] {IMM_I, IMM_U, IMM_S, IMM_B, IMM_J} rv_imm_sel_e;
  typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} rv_src_a_e;
  typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} rv_src_b_e;
  typedef enum logic [0:0] {ALU_ADD, ALU_PASS_B} rv_alu_op_e;

  typedef struct packed {
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    rv_src_a_e       src_a;
    rv_src_b_e       src_b;
    rv_alu_op_e      alu_op;
    logic            wen;
    logic            jump;     // Next PC is PC + imm.
    logic            halt;
    logic            illegal;
  } rv_ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } rv_wb_t;

endpackage

`default_nettype wire

// ==== hw/rv_idu.sv ====
// Instruction decode unit
`default_nettype none

module rv_idu (
  input  rv_core_pkg::rv_inst_u i_inst,
  output rv_core_pkg::rv_ctrl_t o_ctrl
);

  import rv_core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm;

  logic inst_lui;
  logic inst_auipc;
  logic inst_addi;
  logic inst_add;
  logic inst_jal;
  logic inst_ebreak;

  logic type_r;
  logic type_i;
  logic type_u;
  logic type_j;

  rv_imm_sel_e imm_sel;

  assign opcode = i_inst.r.opcode;
  assign funct3 = i_inst.i.funct3;
  assign funct7 = i_inst.r.funct7;

  // Sign-extended immediates, one per format.
  assign imm_i = {{52{i_inst.i.imm12[11]}}, i_inst.i.imm12};
  assign imm_u = {{32{i_inst.u.imm20[19]}}, i_inst.u.imm20, 12'b0};
  assign imm_s = {{52{i_inst.r.funct7[6]}}, i_inst.r.funct7, i_inst.r.rd};
  assign imm_b = {{52{i_inst.r.funct7[6]}}, i_inst.r.rd[0], i_inst.r.funct7[5:0],
                  i_inst.r.rd[4:1], 1'b0};
  assign imm_j = {{44{i_inst.j.imm20}}, i_inst.j.imm19_12, i_inst.j.imm11,
                  i_inst.j.imm10_1, 1'b0};

  assign inst_lui    = (opcode == OP_LUI);
  assign inst_auipc  = (opcode == OP_AUIPC);
  assign inst_addi   = (opcode == OP_IMM) && (funct3 == F3_ADD);
  assign inst_add    = (opcode == OP_REG) && (funct3 == F3_ADD) && (funct7 == F7_ADD);
  assign inst_jal    = (opcode == OP_JAL);
  assign inst_ebreak = (opcode == OP_SYSTEM) && (funct3 == F3_PRIV);

  assign type_r = inst_add;
  assign type_i = inst_addi | inst_ebreak;
  assign type_u = inst_lui | inst_auipc;
  assign type_j = inst_jal;

  always_comb begin
    if (type_u) begin
      imm_sel = IMM_U;
    end else if (type_j) begin
      imm_sel = IMM_J;
    end else begin
      imm_sel = IMM_I;  // R type ignores the immediate.
    end
  end

  always_comb begin
    case (imm_sel)
      IMM_I:   imm = imm_i;
      IMM_U:   imm = imm_u;
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

  always_comb begin
    o_ctrl         = '0;
    o_ctrl.rs1     = i_inst.r.rs1;
    o_ctrl.rs2     = i_inst.r.rs2;
    o_ctrl.rd      = i_inst.r.rd;
    o_ctrl.imm     = imm;
    o_ctrl.src_a   = SRC_A_RS1;
    o_ctrl.src_b   = SRC_B_RS2;
    o_ctrl.alu_op  = ALU_ADD;
    if (inst_lui) begin
      o_ctrl.src_a = SRC_A_ZERO;
      o_ctrl.src_b = SRC_B_IMM;
      o_ctrl.wen   = 1'b1;
    end else if (inst_auipc) begin
      o_ctrl.src_a = SRC_A_PC;
      o_ctrl.src_b = SRC_B_IMM;
      o_ctrl.wen   = 1'b1;
    end else if (inst_addi) begin
      o_ctrl.src_b = SRC_B_IMM;
      o_ctrl.wen   = 1'b1;
    end else if (inst_add) begin
      o_ctrl.wen   = 1'b1;
    end else if (inst_jal) begin
      o_ctrl.src_a = SRC_A_PC;    // Link value.
      o_ctrl.src_b = SRC_B_FOUR;
      o_ctrl.wen   = 1'b1;
      o_ctrl.jump  = 1'b1;
    end else if (inst_ebreak) begin
      o_ctrl.halt  = 1'b1;
    end else begin
      o_ctrl.illegal = 1'b1;
    end
  end

  // Opcode classes must never overlap.
  always_comb begin
    assert ($onehot0({type_r, type_i, type_u, type_j}));
  end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
// Integer register file
`default_nettype none

module rv_regfile (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  logic [4:0]                   i_rs1,
  input  logic [4:0]                   i_rs2,
  output logic [rv_core_pkg::XLEN-1:0] o_rs1_data,
  output logic [rv_core_pkg::XLEN-1:0] o_rs2_data,
  input  rv_core_pkg::rv_wb_t          i_wb
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] regs [1:NUM_REGS-1];  // x0 has no storage.

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int r = 1; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (i_wb.valid && (i_wb.rd != 5'd0)) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // No bypass of the pending write.
  assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

  // A committed write to x0 leaves it reading zero.
  a_x0_zero : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (i_wb.valid && (i_wb.rd == 5'd0)) |=>
      ((i_rs1 != 5'd0) || (o_rs1_data == '0)) &&
      ((i_rs2 != 5'd0) || (o_rs2_data == '0))
  );

endmodule

`default_nettype wire

// ==== hw/rv_alu.sv ====
// Operand select and adder
`default_nettype none

module rv_alu (
  input  rv_core_pkg::rv_ctrl_t         i_ctrl,
  input  logic [rv_core_pkg::XLEN-1:0] i_pc,
  input  logic [rv_core_pkg::XLEN-1:0] i_rs1_data,
  input  logic [rv_core_pkg::XLEN-1:0] i_rs2_data,
  output logic [rv_core_pkg::XLEN-1:0] o_result
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;

  always_comb begin
    case (i_ctrl.src_a)
      SRC_A_RS1:  op_a = i_rs1_data;
      SRC_A_PC:   op_a = i_pc;
      SRC_A_ZERO: op_a = '0;
      default:    op_a = '0;
    endcase
  end

  always_comb begin
    case (i_ctrl.src_b)
      SRC_B_RS2:  op_b = i_rs2_data;
      SRC_B_IMM:  op_b = i_ctrl.imm;
      SRC_B_FOUR: op_b = 64'd4;  // JAL link.
      default:    op_b = '0;
    endcase
  end

  always_comb begin
    if (i_ctrl.alu_op == ALU_PASS_B) begin
      o_result = op_b;
    end else begin
      o_result = op_a + op_b;  // Wraps at 64 bits.
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_pc_unit.sv ====
// Program counter and halt
`default_nettype none

module rv_pc_unit (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  rv_core_pkg::rv_ctrl_t        i_ctrl,
  output logic [rv_core_pkg::XLEN-1:0] o_pc,
  output logic                         o_halt
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] next_pc;
  logic            halt_q;

  assign next_pc = i_ctrl.jump ? (pc_q + i_ctrl.imm) : (pc_q + 64'd4);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q   <= RESET_PC;
      halt_q <= 1'b0;
    end else if (!halt_q) begin
      if (i_ctrl.halt) begin
        halt_q <= 1'b1;  // EBREAK keeps its own PC.
      end else begin
        pc_q <= next_pc;
      end
    end
  end

  assign o_pc   = pc_q;
  assign o_halt = halt_q;

  a_pc_aligned : assert property (
    @(posedge i_clk) disable iff (i_reset) pc_q[1:0] == 2'b00);

  a_halt_freeze : assert property (
    @(posedge i_clk) disable iff (i_reset) halt_q |=> (halt_q && $stable(pc_q)));

endmodule

`default_nettype wire

// ==== hw/rv_core_top.sv ====
// Single-cycle RV64I core
`default_nettype none

module rv_core_top (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  rv_core_pkg::rv_inst_u        i_inst,
  output logic [rv_core_pkg::XLEN-1:0] o_pc,
  output rv_core_pkg::rv_wb_t          o_wb,
  output logic                         o_halt
);

  import rv_core_pkg::*;

  rv_ctrl_t        ctrl;
  rv_wb_t          wb;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] alu_result;
  logic            halt;

  rv_idu u_idu (
    .i_inst (i_inst),
    .o_ctrl (ctrl)
  );

  rv_regfile u_regfile (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_rs1      (ctrl.rs1),
    .i_rs2      (ctrl.rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wb       (wb)
  );

  rv_alu u_alu (
    .i_ctrl     (ctrl),
    .i_pc       (pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_result   (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_ctrl  (ctrl),
    .o_pc    (pc),
    .o_halt  (halt)
  );

  // The regfile drops rd 0 itself.
  always_comb begin
    wb.valid = ctrl.wen && !halt && !i_reset;
    wb.rd    = ctrl.rd;
    wb.data  = alu_result;
  end

  assign o_wb   = wb;
  assign o_pc   = pc;
  assign o_halt = halt;

endmodule

`default_nettype wire

// ==== verification/tb_rv_core.sv ====
// RV64I core testbench
`default_nettype none

module tb_rv_core;

  import rv_core_pkg::*;

  localparam int          MEM_WORDS   = 64;
  localparam int          NUM_TESTS   = 6;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  logic            clk;
  logic            i_reset;
  rv_inst_u        i_inst;
  logic [XLEN-1:0] o_pc;
  rv_wb_t          o_wb;
  logic            o_halt;

  logic [31:0] imem [0:MEM_WORDS-1];
  int          prog_len;
  int          total_words;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] lfsr_state;

  // Reference model state.
  logic [XLEN-1:0] exp_regs [0:NUM_REGS-1];
  logic [XLEN-1:0] exp_pc;
  logic            exp_halt;

  rv_core_top UUT (
    .i_clk   (clk),
    .i_reset (i_reset),
    .i_inst  (i_inst),
    .o_pc    (o_pc),
    .o_wb    (o_wb),
    .o_halt  (o_halt)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      fail_run($sformatf("Timeout: the run went past %0d cycles", cycle_limit));
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[31]};
    end
    return r;
  endfunction

  function automatic logic [11:0] rand_imm12();
    logic [31:0] r;
    r = rand_bits(12);
    return r[11:0];
  endfunction

  function automatic logic [19:0] rand_imm20();
    logic [31:0] r;
    r = rand_bits(20);
    return r[19:0];
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = rand_bits(5);
    return r[4:0];
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return enc_i(OP_IMM, rd, 3'b000, rs1, imm);
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [19:0] imm20);
    return {imm20, rd, op};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  task automatic clear_program;
    for (int a = 0; a < MEM_WORDS; a++) begin
      imem[a] = {a[24:0], 7'b0000000};  // Opcode 0 is not decoded.
    end
    prog_len = 0;
  endtask

  task automatic add_word(input logic [31:0] w);
    imem[prog_len] = w;
    prog_len++;
    total_words++;
    cycle_limit = 16 * NUM_TESTS + 2 * total_words + 64;
  endtask

  function automatic logic [31:0] fetch(input logic [XLEN-1:0] pc);
    logic [XLEN-1:0] idx;
    idx = (pc - RESET_PC) >> 2;
    if (idx < 64'(MEM_WORDS)) begin
      return imem[idx[5:0]];
    end
    return {idx[24:0], 7'b0000000};
  endfunction

  task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: o_pc got %h expected %h", got, exp));
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: o_halt got %h expected %h", got, exp));
    end
  endtask

  task automatic check_wb(input rv_wb_t got, input rv_wb_t exp);
    if (got.valid !== exp.valid) begin
      fail_run($sformatf("Error: o_wb.valid got %h expected %h", got.valid, exp.valid));
    end else if (exp.valid && (got.rd !== exp.rd)) begin
      fail_run($sformatf("Error: o_wb.rd got %h expected %h", got.rd, exp.rd));
    end else if (exp.valid && (got.data !== exp.data)) begin
      fail_run($sformatf("Error: o_wb.data got %h expected %h", got.data, exp.data));
    end
  endtask

  // Called 1 unit after an edge; checks at the middle of the cycle.
  task automatic step_word(input logic [31:0] w);
    rv_wb_t          exp_wb;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] next_pc;
    logic            is_ebreak;
    i_inst = w;
    #1;
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_u = {{32{w[31]}}, w[31:12], 12'h000};
    imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    exp_wb    = '0;
    exp_wb.rd = w[11:7];
    next_pc   = exp_pc + 64'd4;
    is_ebreak = 1'b0;
    case (w[6:0])
      OP_LUI: begin
        exp_wb.valid = 1'b1;
        exp_wb.data  = imm_u;
      end
      OP_AUIPC: begin
        exp_wb.valid = 1'b1;
        exp_wb.data  = exp_pc + imm_u;
      end
      OP_IMM: begin
        exp_wb.valid = (w[14:12] == 3'b000);
        exp_wb.data  = exp_regs[w[19:15]] + imm_i;
      end
      OP_REG: begin
        exp_wb.valid = (w[14:12] == 3'b000) && (w[31:25] == 7'b0000000);
        exp_wb.data  = exp_regs[w[19:15]] + exp_regs[w[24:20]];
      end
      OP_JAL: begin
        exp_wb.valid = 1'b1;
        exp_wb.data  = exp_pc + 64'd4;
        next_pc      = exp_pc + imm_j;
      end
      OP_SYSTEM: is_ebreak = (w[14:12] == 3'b000);
      default: ;
    endcase
    if (exp_halt) begin
      exp_wb.valid = 1'b0;
    end
    check_halt(o_halt, exp_halt);
    check_pc(o_pc, exp_pc);
    check_wb(o_wb, exp_wb);
    if (!exp_halt) begin
      if (exp_wb.valid && (exp_wb.rd != 5'd0)) begin
        exp_regs[exp_wb.rd] = exp_wb.data;
      end
      if (is_ebreak) begin
        exp_halt = 1'b1;  // PC stays on the EBREAK.
      end else begin
        exp_pc = next_pc;
      end
    end
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #1;
    step_word(fetch(o_pc));
  endtask

  task automatic next_forced(input logic [31:0] w);
    @(posedge clk);
    #1;
    step_word(w);
  endtask

  task automatic pulse_reset;
    @(posedge clk);
    #1;
    i_reset = 1'b1;
    i_inst  = fetch(RESET_PC);
    repeat (16) begin
      @(posedge clk);
      #1;
      check_pc(o_pc, RESET_PC);
      check_halt(o_halt, 1'b0);
      check_wb(o_wb, '0);
    end
    i_reset = 1'b0;
    for (int r = 0; r < NUM_REGS; r++) begin
      exp_regs[r] = '0;
    end
    exp_pc   = RESET_PC;
    exp_halt = 1'b0;
  endtask

  // Runs until the core halts, then a few frozen cycles.
  task automatic run_program;
    step_word(fetch(o_pc));
    while (!o_halt) begin
      next_cycle();
    end
    repeat (3) next_cycle();
  endtask

  task automatic test_reset;
    clear_program();
    add_word(enc_addi(5'd1, 5'd0, 12'h001));
    add_word(EBREAK_WORD);
    pulse_reset();
    run_program();
  endtask

  task automatic test_lui_auipc;
    clear_program();
    add_word(enc_u(OP_LUI, 5'd1, rand_imm20()));
    add_word(enc_u(OP_LUI, 5'd2, 20'h80000));
    add_word(enc_u(OP_AUIPC, 5'd3, rand_imm20()));
    add_word(enc_u(OP_AUIPC, 5'd4, 20'hfffff));  // PC - 4096.
    add_word(EBREAK_WORD);
    pulse_reset();
    run_program();
  endtask

  task automatic test_addi_chain;
    clear_program();
    add_word(enc_addi(5'd1, 5'd0, rand_imm12()));
    repeat (6) add_word(enc_addi(rand_reg(), rand_reg(), rand_imm12()));
    add_word(enc_addi(5'd0, 5'd1, 12'h7ff));
    add_word(enc_addi(5'd7, 5'd0, 12'h800));  // x0 must read back as zero.
    add_word(EBREAK_WORD);
    pulse_reset();
    run_program();
  endtask

  task automatic test_add;
    clear_program();
    add_word(enc_u(OP_LUI, 5'd1, 20'h80000));
    add_word(enc_r(7'b0000000, 5'd2, 5'd1, 5'd1));
    add_word(enc_addi(5'd3, 5'd0, 12'hfff));
    add_word(enc_addi(5'd4, 5'd0, 12'h001));
    add_word(enc_r(7'b0000000, 5'd5, 5'd3, 5'd4));  // Wraps to zero.
    add_word(enc_r(7'b0000000, 5'd6, 5'd2, 5'd3));
    add_word(EBREAK_WORD);
    pulse_reset();
    run_program();
  endtask

  task automatic test_jal;
    clear_program();
    add_word(enc_jal(5'd1, 21'd12));
    add_word(enc_addi(5'd3, 5'd0, 12'h005));
    add_word(enc_jal(5'd4, 21'd12));
    add_word(enc_jal(5'd2, 21'h1f_fff8));  // Back by 8.
    add_word(enc_addi(5'd9, 5'd0, 12'h001));
    add_word(EBREAK_WORD);
    pulse_reset();
    run_program();
  endtask

  task automatic test_unknown_halt;
    clear_program();
    add_word(32'hffff_ffff);
    add_word(enc_addi(5'd1, 5'd0, 12'h005));
    add_word(enc_r(7'b0000001, 5'd2, 5'd1, 5'd1));
    add_word(enc_i(OP_IMM, 5'd3, 3'b001, 5'd1, 12'h001));
    add_word(EBREAK_WORD);
    add_word(enc_addi(5'd2, 5'd0, 12'h009));
    pulse_reset();
    run_program();
    repeat (3) next_forced(enc_addi(5'd2, 5'd1, rand_imm12()));
  endtask

  initial begin
    clk         = 1'b0;
    i_reset     = 1'b1;
    i_inst      = '0;
    cycle_count = 0;
    total_words = 0;
    prog_len    = 0;
    lfsr_state  = 32'h81c5;
    cycle_limit = 16 * NUM_TESTS + 64;
    exp_pc      = RESET_PC;
    exp_halt    = 1'b0;
    test_reset();
    test_lui_auipc();
    test_addi_chain();
    test_add();
    test_jal();
    test_unknown_halt();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/rv_core_pkg.sv
hw/rv_idu.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_pc_unit.sv
hw/rv_core_top.sv
verification/tb_rv_core.sv

// ==== Makefile ====
# Verilator flow for the RV64I core

TB_TOP := tb_rv_core

.PHONY: all lint sim clean

all: sim

# Lints the RTL on its own, then the whole bench.
lint:
	verilator --lint-only --timing --top-module rv_core_top \
		hw/rv_core_pkg.sv hw/rv_idu.sv hw/rv_regfile.sv \
		hw/rv_alu.sv hw/rv_pc_unit.sv hw/rv_core_top.sv
	verilator --lint-only --timing -f filelist.f --top-module $(TB_TOP)

obj_dir/V$(TB_TOP): filelist.f hw/*.sv verification/*.sv
	verilator --binary --timing --assert -f filelist.f \
		--top-module $(TB_TOP) -o V$(TB_TOP)

# The log decides pass or fail.
sim: obj_dir/V$(TB_TOP)
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
